// ==== rtl/uncached_pkg.sv ====
package uncached_pkg;

    ////////////////////////////////////////////////////////////
    // datapath widths
    ////////////////////////////////////////////////////////////

    localparam int addr_w = 32;
    localparam int data_w = 32;
    // one strobe bit per byte lane
    localparam int strb_w = 4;

    ////////////////////////////////////////////////////////////
    // access size from the pipeline
    ////////////////////////////////////////////////////////////

    localparam logic [1:0] acc_byte = 2'd0;
    localparam logic [1:0] acc_half = 2'd1;
    localparam logic [1:0] acc_word = 2'd2;

    ////////////////////////////////////////////////////////////
    // size field on the memory bus
    ////////////////////////////////////////////////////////////

    // same numbering as the pipeline codes
    localparam logic [1:0] bus_size_byte = 2'd0;
    localparam logic [1:0] bus_size_half = 2'd1;
    localparam logic [1:0] bus_size_word = 2'd2;

endpackage

// ==== rtl/store_format.sv ====
`timescale 1ns/1ps

module store_format (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic                              valid,
    input  logic                              wr,
    input  logic                              sign_ext,
    input  logic [1:0]                        size,
    input  logic [uncached_pkg::addr_w-1:0]   addr,
    input  logic [uncached_pkg::data_w-1:0]   wdata,
    output logic                              ready,
    output logic                              fmt_valid,
    output logic                              fmt_wr,
    output logic                              fmt_sign,
    output logic [1:0]                        fmt_size,
    output logic [uncached_pkg::addr_w-1:0]   fmt_addr,
    output logic [uncached_pkg::data_w-1:0]   fmt_wdata,
    output logic [uncached_pkg::strb_w-1:0]   fmt_strb,
    input  logic                              fmt_ready
);

    logic [uncached_pkg::strb_w-1:0] strb_next;
    logic [uncached_pkg::data_w-1:0] wdata_next;
    logic [uncached_pkg::addr_w-1:0] addr_next;

    // free slot, or the held entry leaves this cycle
    assign ready = !fmt_valid || fmt_ready;

    // strobe, lane replication and natural alignment
    always_comb begin
        case (size)
            uncached_pkg::acc_byte: begin
                strb_next  = 4'b0001 << addr[1:0];
                wdata_next = {4{wdata[7:0]}};
                addr_next  = addr;
            end
            uncached_pkg::acc_half: begin
                strb_next  = addr[1] ? 4'b1100 : 4'b0011;
                wdata_next = {2{wdata[15:0]}};
                addr_next  = {addr[uncached_pkg::addr_w-1:1], 1'b0};
            end
            default: begin
                strb_next  = 4'b1111;
                wdata_next = wdata;
                addr_next  = {addr[uncached_pkg::addr_w-1:2], 2'b00};
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            fmt_valid <= 1'b0;
        end else if (valid && ready) begin
            fmt_valid <= 1'b1;
        end else if (fmt_ready) begin
            fmt_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (valid && ready) begin
            fmt_wr    <= wr;
            fmt_sign  <= sign_ext;
            fmt_size  <= size;
            fmt_addr  <= addr_next;
            fmt_wdata <= wdata_next;
            fmt_strb  <= strb_next;
        end
    end

    // a stalled pipeline request keeps its payload until taken
    a_pipe_hold: assert property (@(posedge clk) disable iff (!rstn)
        valid && !ready |=> valid && $stable({wr, sign_ext, size, addr, wdata}))
        else $error("pipeline request changed while stalled");

endmodule

// ==== rtl/bus_access.sv ====
`timescale 1ns/1ps

module bus_access (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic                              fmt_valid,
    input  logic                              fmt_wr,
    input  logic                              fmt_sign,
    input  logic [1:0]                        fmt_size,
    input  logic [uncached_pkg::addr_w-1:0]   fmt_addr,
    input  logic [uncached_pkg::data_w-1:0]   fmt_wdata,
    input  logic [uncached_pkg::strb_w-1:0]   fmt_strb,
    output logic                              fmt_ready,
    output logic                              mem_req,
    output logic                              mem_wr,
    output logic [1:0]                        mem_size,
    output logic [uncached_pkg::strb_w-1:0]   mem_strb,
    output logic [uncached_pkg::addr_w-1:0]   mem_addr,
    output logic [uncached_pkg::data_w-1:0]   mem_wdata,
    input  logic                              mem_addr_ok,
    input  logic                              mem_data_ok,
    input  logic [uncached_pkg::data_w-1:0]   mem_rdata,
    output logic                              rd_valid,
    output logic [uncached_pkg::data_w-1:0]   rd_data,
    output logic [1:0]                        rd_offset,
    output logic [1:0]                        rd_size,
    output logic                              rd_sign
);

    typedef enum logic [1:0] {st_idle, st_req, st_wait} state_t;

    state_t                          state;
    state_t                          next_state;
    logic                            wr_q;
    logic                            sign_q;
    logic [1:0]                      size_q;
    logic [uncached_pkg::addr_w-1:0] addr_q;
    logic [uncached_pkg::data_w-1:0] wdata_q;
    logic [uncached_pkg::strb_w-1:0] strb_q;

    ////////////////////////////////////////////////////////////
    // request / address / data sequencing
    ////////////////////////////////////////////////////////////

    always_comb begin
        next_state = state;
        case (state)
            st_idle: if (fmt_valid) next_state = st_req;
            st_req:  if (mem_addr_ok) next_state = wr_q ? st_idle : st_wait;
            st_wait: if (mem_data_ok) next_state = st_idle;
            default: next_state = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state   <= st_idle;
            mem_req <= 1'b0;
        end else begin
            state   <= next_state;
            mem_req <= (next_state == st_req);
        end
    end

    // capture the access on leaving idle; unknown size codes go out as a word
    always_ff @(posedge clk) begin
        if (state == st_idle && fmt_valid) begin
            wr_q    <= fmt_wr;
            sign_q  <= fmt_sign;
            addr_q  <= fmt_addr;
            wdata_q <= fmt_wdata;
            strb_q  <= fmt_strb;
            case (fmt_size)
                uncached_pkg::bus_size_byte: size_q <= uncached_pkg::bus_size_byte;
                uncached_pkg::bus_size_half: size_q <= uncached_pkg::bus_size_half;
                default:                     size_q <= uncached_pkg::bus_size_word;
            endcase
        end
    end

    // store done at address accept, load done at data return
    assign fmt_ready = (state == st_req && mem_addr_ok && wr_q) ||
                       (state == st_wait && mem_data_ok);

    assign mem_wr    = wr_q;
    assign mem_size  = size_q;
    assign mem_strb  = strb_q;
    assign mem_addr  = {addr_q[uncached_pkg::addr_w-1:2], 2'b00};
    assign mem_wdata = wdata_q;

    assign rd_valid  = (state == st_wait) && mem_data_ok;
    assign rd_data   = mem_rdata;
    assign rd_offset = addr_q[1:0];
    assign rd_size   = size_q;
    assign rd_sign   = sign_q;

    ////////////////////////////////////////////////////////////
    // bus protocol checks
    ////////////////////////////////////////////////////////////

    // address accept only answers a pending request
    a_addr_ok_req: assert property (@(posedge clk) disable iff (!rstn)
        mem_addr_ok |-> mem_req)
        else $error("mem_addr_ok without mem_req");

    // offered access held steady until taken
    a_fmt_hold: assert property (@(posedge clk) disable iff (!rstn)
        fmt_valid && !fmt_ready |=> fmt_valid &&
            $stable({fmt_wr, fmt_sign, fmt_size, fmt_addr, fmt_wdata, fmt_strb}))
        else $error("formatted access changed before fmt_ready");

    a_data_ok_state: assert property (@(posedge clk) disable iff (!rstn)
        mem_data_ok |-> state == st_wait)
        else $error("mem_data_ok outside wait-data state");

endmodule

// ==== rtl/load_align.sv ====
`timescale 1ns/1ps

module load_align (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic                              rd_valid,
    input  logic                              rd_sign,
    input  logic [uncached_pkg::data_w-1:0]   rd_data,
    input  logic [1:0]                        rd_offset,
    input  logic [1:0]                        rd_size,
    output logic                              result_valid,
    output logic [uncached_pkg::data_w-1:0]   result_data
);

    logic [7:0]                      byte_lane;
    logic [15:0]                     half_lane;
    logic [uncached_pkg::data_w-1:0] extended;

    ////////////////////////////////////////////////////////////
    // lane select and extension
    ////////////////////////////////////////////////////////////

    always_comb begin
        byte_lane = rd_data[{rd_offset, 3'b000} +: 8];
        // halfword lane picked by offset bit 1 only
        half_lane = rd_offset[1] ? rd_data[31:16] : rd_data[15:0];
        case (rd_size)
            uncached_pkg::acc_byte: begin
                extended = {{(uncached_pkg::data_w - 8){rd_sign & byte_lane[7]}},
                            byte_lane};
            end
            uncached_pkg::acc_half: begin
                extended = {{(uncached_pkg::data_w - 16){rd_sign & half_lane[15]}},
                            half_lane};
            end
            default: begin
                extended = rd_data;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= rd_valid;
        end
    end

    // result held until the next load returns
    always_ff @(posedge clk) begin
        if (rd_valid) begin
            result_data <= extended;
        end
    end

endmodule

// ==== rtl/uncached_lsu_top.sv ====
`timescale 1ns/1ps

module uncached_lsu_top (
    input  logic                              clk,
    input  logic                              rstn,
    // pipeline side
    input  logic                              valid,
    output logic                              ready,
    input  logic                              wr,
    input  logic [1:0]                        size,
    input  logic                              sign_ext,
    input  logic [uncached_pkg::addr_w-1:0]   addr,
    input  logic [uncached_pkg::data_w-1:0]   wdata,
    // memory bus
    output logic                              mem_req,
    output logic                              mem_wr,
    output logic [1:0]                        mem_size,
    output logic [uncached_pkg::strb_w-1:0]   mem_strb,
    output logic [uncached_pkg::addr_w-1:0]   mem_addr,
    output logic [uncached_pkg::data_w-1:0]   mem_wdata,
    input  logic                              mem_addr_ok,
    input  logic                              mem_data_ok,
    input  logic [uncached_pkg::data_w-1:0]   mem_rdata,
    // writeback
    output logic                              result_valid,
    output logic [uncached_pkg::data_w-1:0]   result_data
);

    // store_format to bus_access
    logic                            fmt_valid;
    logic                            fmt_ready;
    logic                            fmt_wr;
    logic                            fmt_sign;
    logic [1:0]                      fmt_size;
    logic [uncached_pkg::addr_w-1:0] fmt_addr;
    logic [uncached_pkg::data_w-1:0] fmt_wdata;
    logic [uncached_pkg::strb_w-1:0] fmt_strb;

    // bus_access to load_align
    logic                            rd_valid;
    logic [uncached_pkg::data_w-1:0] rd_data;
    logic [1:0]                      rd_offset;
    logic [1:0]                      rd_size;
    logic                            rd_sign;

    store_format i_store_format (
        .clk       (clk),
        .rstn      (rstn),
        .valid     (valid),
        .wr        (wr),
        .sign_ext  (sign_ext),
        .size      (size),
        .addr      (addr),
        .wdata     (wdata),
        .ready     (ready),
        .fmt_valid (fmt_valid),
        .fmt_wr    (fmt_wr),
        .fmt_sign  (fmt_sign),
        .fmt_size  (fmt_size),
        .fmt_addr  (fmt_addr),
        .fmt_wdata (fmt_wdata),
        .fmt_strb  (fmt_strb),
        .fmt_ready (fmt_ready)
    );

    bus_access i_bus_access (
        .clk         (clk),
        .rstn        (rstn),
        .fmt_valid   (fmt_valid),
        .fmt_wr      (fmt_wr),
        .fmt_sign    (fmt_sign),
        .fmt_size    (fmt_size),
        .fmt_addr    (fmt_addr),
        .fmt_wdata   (fmt_wdata),
        .fmt_strb    (fmt_strb),
        .fmt_ready   (fmt_ready),
        .mem_req     (mem_req),
        .mem_wr      (mem_wr),
        .mem_size    (mem_size),
        .mem_strb    (mem_strb),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_addr_ok (mem_addr_ok),
        .mem_data_ok (mem_data_ok),
        .mem_rdata   (mem_rdata),
        .rd_valid    (rd_valid),
        .rd_data     (rd_data),
        .rd_offset   (rd_offset),
        .rd_size     (rd_size),
        .rd_sign     (rd_sign)
    );

    load_align i_load_align (
        .clk          (clk),
        .rstn         (rstn),
        .rd_valid     (rd_valid),
        .rd_sign      (rd_sign),
        .rd_data      (rd_data),
        .rd_offset    (rd_offset),
        .rd_size      (rd_size),
        .result_valid (result_valid),
        .result_data  (result_data)
    );

endmodule

// ==== test/lsu_checker.sv ====
`timescale 1ns/1ps

module lsu_checker (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic                              valid,
    input  logic                              ready,
    input  logic                              wr,
    input  logic [1:0]                        size,
    input  logic [uncached_pkg::addr_w-1:0]   addr,
    input  logic [uncached_pkg::data_w-1:0]   wdata,
    input  logic [uncached_pkg::data_w-1:0]   exp_data,
    input  logic                              mem_req,
    input  logic                              mem_wr,
    input  logic [1:0]                        mem_size,
    input  logic [uncached_pkg::strb_w-1:0]   mem_strb,
    input  logic [uncached_pkg::addr_w-1:0]   mem_addr,
    input  logic [uncached_pkg::data_w-1:0]   mem_wdata,
    input  logic                              mem_addr_ok,
    input  logic                              result_valid,
    input  logic [uncached_pkg::data_w-1:0]   result_data,
    input  int                                total,
    input  logic                              all_sent,
    output logic                              done,
    output int                                errors
);

    // accepted accesses in pipeline order
    logic                            acc_wr[$];
    logic [1:0]                      acc_size[$];
    logic [uncached_pkg::addr_w-1:0] acc_addr[$];
    logic [uncached_pkg::data_w-1:0] acc_wdata[$];
    logic [uncached_pkg::data_w-1:0] acc_exp[$];
    bit                              acc_bad[$];
    int                              load_ids[$];
    int                              bus_idx;
    int                              completed;
    int                              stalls;
    int                              id;
    logic                            rstn_q;

    ////////////////////////////////////////////////////////////
    // expected bus values
    ////////////////////////////////////////////////////////////

    function automatic logic [3:0] expect_strb(input logic [1:0] sz, input logic [31:0] a);
        if (sz == uncached_pkg::acc_word) begin
            return 4'b1111;
        end else if (sz == uncached_pkg::acc_half) begin
            return a[1] ? 4'b1100 : 4'b0011;
        end
        case (a[1:0])
            2'd0:    return 4'b0001;
            2'd1:    return 4'b0010;
            2'd2:    return 4'b0100;
            default: return 4'b1000;
        endcase
    endfunction

    function automatic logic [31:0] expect_lanes(input logic [1:0] sz, input logic [31:0] d);
        case (sz)
            uncached_pkg::acc_byte: return {d[7:0], d[7:0], d[7:0], d[7:0]};
            uncached_pkg::acc_half: return {d[15:0], d[15:0]};
            default:                return d;
        endcase
    endfunction

    function automatic logic [1:0] expect_bus_size(input logic [1:0] sz);
        case (sz)
            uncached_pkg::acc_byte: return uncached_pkg::bus_size_byte;
            uncached_pkg::acc_half: return uncached_pkg::bus_size_half;
            default:                return uncached_pkg::bus_size_word;
        endcase
    endfunction

    task automatic check_value(input string name, input int idx,
                               input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch %s in access %0d: got %h, expected %h", name, idx, got, exp);
            errors++;
            acc_bad[idx] = 1'b1;
        end
    endtask

    task automatic report_access(input int idx);
        $display("access %0d %s size %0d addr %h: %s", idx, acc_wr[idx] ? "store" : "load ",
                 acc_size[idx], acc_addr[idx], acc_bad[idx] ? "fail" : "pass");
        completed++;
    endtask

    // bus transactions follow acceptance order
    task automatic check_bus();
        if (bus_idx >= acc_wr.size()) begin
            $display("bus transaction seen with no accepted access left");
            errors++;
        end else begin
            id = bus_idx;
            bus_idx++;
            check_value("mem_addr", id, mem_addr, {acc_addr[id][31:2], 2'b00});
            check_value("mem_wr", id, 32'(mem_wr), 32'(acc_wr[id]));
            check_value("mem_size", id, 32'(mem_size), 32'(expect_bus_size(acc_size[id])));
            if (acc_wr[id]) begin
                check_value("mem_strb", id, 32'(mem_strb),
                            32'(expect_strb(acc_size[id], acc_addr[id])));
                check_value("mem_wdata", id, mem_wdata,
                            expect_lanes(acc_size[id], acc_wdata[id]));
                report_access(id);
            end else begin
                load_ids.push_back(id);
            end
        end
    endtask

    task automatic check_result();
        if (load_ids.size() == 0) begin
            $display("result_valid seen with no load outstanding");
            errors++;
        end else begin
            id = load_ids.pop_front();
            check_value("result_data", id, result_data, acc_exp[id]);
            report_access(id);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // monitor
    ////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (!rstn) begin
            acc_wr.delete();
            acc_size.delete();
            acc_addr.delete();
            acc_wdata.delete();
            acc_exp.delete();
            acc_bad.delete();
            load_ids.delete();
            bus_idx   = 0;
            completed = 0;
            stalls    = 0;
            errors    = 0;
            done      = 1'b0;
        end else begin
            // first cycle out of reset
            if (!rstn_q && !(ready && !mem_req && !result_valid)) begin
                $display("idle state wrong after reset: ready %b mem_req %b result_valid %b",
                         ready, mem_req, result_valid);
                errors++;
            end
            if (valid && !ready) begin
                stalls++;
            end
            if (valid && ready) begin
                acc_wr.push_back(wr);
                acc_size.push_back(size);
                acc_addr.push_back(addr);
                acc_wdata.push_back(wdata);
                acc_exp.push_back(exp_data);
                acc_bad.push_back(1'b0);
            end
            if (mem_req && mem_addr_ok) begin
                check_bus();
            end
            if (result_valid) begin
                check_result();
            end
            if (all_sent && !done && completed == total) begin
                if (stalls == 0) begin
                    $display("ready never dropped, back-pressure was not exercised");
                    errors++;
                end
                $display("%0d of %0d accesses checked, %0d errors", completed, total, errors);
                done = 1'b1;
            end
        end
        rstn_q = rstn;
    end

endmodule

// ==== test/tb_uncached_lsu.sv ====
`timescale 1ns/1ps

module tb_uncached_lsu;

    localparam string input_file    = "test/lsu_input.txt";
    localparam int    ready_timeout = 100;
    localparam int    done_timeout  = 1000;

    logic                            clk;
    logic                            rstn;
    logic                            valid;
    logic                            ready;
    logic                            wr;
    logic [1:0]                      size;
    logic                            sign_ext;
    logic [uncached_pkg::addr_w-1:0] addr;
    logic [uncached_pkg::data_w-1:0] wdata;
    logic                            mem_req;
    logic                            mem_wr;
    logic [1:0]                      mem_size;
    logic [uncached_pkg::strb_w-1:0] mem_strb;
    logic [uncached_pkg::addr_w-1:0] mem_addr;
    logic [uncached_pkg::data_w-1:0] mem_wdata;
    logic                            mem_addr_ok;
    logic                            mem_data_ok;
    logic [uncached_pkg::data_w-1:0] mem_rdata;
    logic                            result_valid;
    logic [uncached_pkg::data_w-1:0] result_data;

    // expected load result travels with each access
    logic [uncached_pkg::data_w-1:0] exp_data;
    logic                            all_sent;
    logic                            done;
    logic                            timed_out;
    int                              total;
    int                              errors;

    // access table
    logic                            t_wr[$];
    logic [1:0]                      t_size[$];
    logic                            t_sign[$];
    logic [uncached_pkg::addr_w-1:0] t_addr[$];
    logic [uncached_pkg::data_w-1:0] t_wdata[$];
    logic [uncached_pkg::data_w-1:0] t_exp[$];

    // words never written read back as address ^ 32'h5a5a0000
    logic [31:0] mem_words [logic [31:0]];
    logic [31:0] rng_state;

    uncached_lsu_top i_dut (
        .clk          (clk),
        .rstn         (rstn),
        .valid        (valid),
        .ready        (ready),
        .wr           (wr),
        .size         (size),
        .sign_ext     (sign_ext),
        .addr         (addr),
        .wdata        (wdata),
        .mem_req      (mem_req),
        .mem_wr       (mem_wr),
        .mem_size     (mem_size),
        .mem_strb     (mem_strb),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_addr_ok  (mem_addr_ok),
        .mem_data_ok  (mem_data_ok),
        .mem_rdata    (mem_rdata),
        .result_valid (result_valid),
        .result_data  (result_data)
    );

    lsu_checker i_checker (
        .clk          (clk),
        .rstn         (rstn),
        .valid        (valid),
        .ready        (ready),
        .wr           (wr),
        .size         (size),
        .addr         (addr),
        .wdata        (wdata),
        .exp_data     (exp_data),
        .mem_req      (mem_req),
        .mem_wr       (mem_wr),
        .mem_size     (mem_size),
        .mem_strb     (mem_strb),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_addr_ok  (mem_addr_ok),
        .result_valid (result_valid),
        .result_data  (result_data),
        .total        (total),
        .all_sent     (all_sent),
        .done         (done),
        .errors       (errors)
    );

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // 0 to 3 cycles of bus delay
    task automatic draw_delay(output logic [1:0] d);
        rng_state = xorshift32(rng_state);
        d = rng_state[1:0];
    endtask

    function automatic logic [31:0] read_word(input logic [31:0] waddr);
        if (mem_words.exists(waddr)) begin
            return mem_words[waddr];
        end
        return waddr ^ 32'h5a5a0000;
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old,
                                                 input logic [31:0] data,
                                                 input logic [3:0]  strb);
        logic [31:0] w;
        w[7:0]   = strb[0] ? data[7:0]   : old[7:0];
        w[15:8]  = strb[1] ? data[15:8]  : old[15:8];
        w[23:16] = strb[2] ? data[23:16] : old[23:16];
        w[31:24] = strb[3] ? data[31:24] : old[31:24];
        return w;
    endfunction

    // lines that do not scan as six hex fields are comments
    task automatic read_vectors();
        int          fd;
        int          n;
        string       line;
        logic [31:0] f_op;
        logic [31:0] f_size;
        logic [31:0] f_sign;
        logic [31:0] f_addr;
        logic [31:0] f_wdata;
        logic [31:0] f_exp;
        fd = $fopen(input_file, "r");
        if (fd == 0) begin
            $display("cannot open %s", input_file);
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                n = $sscanf(line, "%h %h %h %h %h %h",
                            f_op, f_size, f_sign, f_addr, f_wdata, f_exp);
                if (n == 6) begin
                    t_wr.push_back(f_op[0]);
                    t_size.push_back(f_size[1:0]);
                    t_sign.push_back(f_sign[0]);
                    t_addr.push_back(f_addr);
                    t_wdata.push_back(f_wdata);
                    t_exp.push_back(f_exp);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic drive_access(input int i);
        valid    = 1'b1;
        wr       = t_wr[i];
        size     = t_size[i];
        sign_ext = t_sign[i];
        addr     = t_addr[i];
        wdata    = t_wdata[i];
        exp_data = t_exp[i];
    endtask

    ////////////////////////////////////////////////////////////
    // clock and memory model
    ////////////////////////////////////////////////////////////

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // answers on the falling edge, the DUT takes it on the next rising edge
    initial begin : memory_model
        logic [31:0] read_addr;
        logic        data_pending;
        logic [1:0]  addr_delay;
        logic [1:0]  data_delay;
        mem_addr_ok  = 1'b0;
        mem_data_ok  = 1'b0;
        mem_rdata    = '0;
        rng_state    = 32'h61edfdee;
        read_addr    = '0;
        data_pending = 1'b0;
        data_delay   = 2'd0;
        draw_delay(addr_delay);
        forever begin
            @(negedge clk);
            mem_addr_ok = 1'b0;
            mem_data_ok = 1'b0;
            if (!rstn) begin
                data_pending = 1'b0;
            end else if (data_pending) begin
                if (data_delay == 2'd0) begin
                    mem_data_ok  = 1'b1;
                    mem_rdata    = read_word(read_addr);
                    data_pending = 1'b0;
                end else begin
                    data_delay = data_delay - 2'd1;
                end
            end else if (mem_req) begin
                if (addr_delay == 2'd0) begin
                    mem_addr_ok = 1'b1;
                    if (mem_wr) begin
                        mem_words[mem_addr] = merge_bytes(read_word(mem_addr), mem_wdata,
                                                          mem_strb);
                    end else begin
                        read_addr    = mem_addr;
                        data_pending = 1'b1;
                        draw_delay(data_delay);
                    end
                    draw_delay(addr_delay);
                end else begin
                    addr_delay = addr_delay - 2'd1;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////

    initial begin
        int   cycles;
        logic accepted;
        rstn      = 1'b0;
        valid     = 1'b0;
        wr        = 1'b0;
        size      = 2'd0;
        sign_ext  = 1'b0;
        addr      = '0;
        wdata     = '0;
        exp_data  = '0;
        all_sent  = 1'b0;
        timed_out = 1'b0;
        total     = 0;
        read_vectors();
        total = t_wr.size();
        repeat (8) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        // one idle cycle, then accesses back to back
        @(negedge clk);
        for (int i = 0; i < total && !timed_out; i++) begin
            drive_access(i);
            accepted = 1'b0;
            cycles   = 0;
            while (!accepted && cycles < ready_timeout) begin
                @(posedge clk);
                accepted = ready;
                cycles++;
            end
            if (!accepted) begin
                $display("timeout: access %0d was never accepted, ready stayed low", i);
                timed_out = 1'b1;
            end
            @(negedge clk);
        end
        valid    = 1'b0;
        all_sent = !timed_out;
        cycles   = 0;
        while (!timed_out && !done && cycles < done_timeout) begin
            @(negedge clk);
            cycles++;
        end
        if (!timed_out && !done) begin
            $display("timeout: not all %0d accesses completed", total);
            timed_out = 1'b1;
        end
        if (timed_out || errors != 0) begin
            $display("TESTS FAILED");
        end else begin
            $display("TESTS PASSED");
        end
        $finish;
    end

endmodule

// ==== test/lsu_input.txt ====
// op (0 load, 1 store)  size (0 byte, 1 half, 2 word)  sign  addr  store data  load result
// the load result column is unused for stores
0 2 0 00000010 00000000 5a5a0010
0 2 1 f0f08004 00000000 aaaa8004
0 0 1 0001c3b0 00000000 ffffffb0
0 0 0 0001c3b1 00000000 000000c3
0 0 1 0001c3b2 00000000 0000005b
0 0 1 0001c3b3 00000000 0000005a
0 0 0 f0f08004 00000000 00000004
0 0 1 f0f08005 00000000 ffffff80
0 0 0 f0f08006 00000000 000000aa
0 1 1 0001c3b0 00000000 ffffc3b0
0 1 0 0001c3b2 00000000 00005a5b
0 1 1 f0f08006 00000000 ffffaaaa
0 1 1 f0f08005 00000000 ffff8004
1 0 0 00000201 ffffffe7 00000000
1 1 0 00000202 0000beef 00000000
0 2 0 00000200 00000000 beefe700
1 2 0 00000300 12345678 00000000
1 1 0 00000300 0000abcd 00000000
1 0 0 00000303 000000fe 00000000
0 2 0 00000300 00000000 fe34abcd
0 0 1 00000302 00000000 00000034
0 1 1 00000302 00000000 fffffe34
1 0 0 00000400 00000081 00000000
0 0 1 00000400 00000000 ffffff81

// ==== list.f ====
rtl/uncached_pkg.sv
rtl/store_format.sv
rtl/bus_access.sv
rtl/load_align.sv
rtl/uncached_lsu_top.sv
test/lsu_checker.sv
test/tb_uncached_lsu.sv

// ==== run.sh ====
#!/bin/sh
# build and run the uncached LSU testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module tb_uncached_lsu -f list.f || exit 1
out=$(./obj_dir/Vtb_uncached_lsu)
echo "$out"
echo "$out" | grep -qx "TESTS PASSED" && exit 0 || exit 1
